//--- logic/sifhPkg.sv
package sifhPkg;

    // controller states
    // clear runs once after reset, then accumulate/drain/scan loop per pixel
    typedef enum logic [1:0] {
        stClear      = 2'd0,
        stAccumulate = 2'd1,
        stDrain      = 2'd2,
        stScan       = 2'd3
    } fsmState_t;

    // peak finder phases
    typedef enum logic [1:0] {
        phIdle  = 2'd0,
        phTrack = 2'd1,
        phEmit  = 2'd2
    } scanPhase_t;

    // timestamp width in bits
    localparam int defStampWidth = 10;

    // upper timestamp bits that pick the bin
    localparam int defBinBits = 5;

    // histogram count width, saturating
    localparam int defCountWidth = 8;

    // pixels per frame before wrap to pixel 0
    localparam int defPixelNum = 4;

    // acquisitions per pixel
    localparam int defAcqNum = 4;

    // timestamps per acquisition
    localparam int defDataNum = 2;

endpackage

//--- logic/histRam.sv
`timescale 1ns/1ps

module histRam #(
    parameter int binBits = sifhPkg::defBinBits,
    parameter int countWidth = sifhPkg::defCountWidth,
    parameter int pixelNum = sifhPkg::defPixelNum,
    localparam int pixWidth = (pixelNum > 1) ? $clog2(pixelNum) : 1,
    localparam int addrWidth = pixWidth + binBits,
    localparam int depth = pixelNum * (2 ** binBits)
) (
    input  logic                  clk,
    input  logic                  ramWrite,
    input  logic [addrWidth-1:0]  ramWaddr,
    input  logic [countWidth-1:0] ramWdata,
    input  logic [addrWidth-1:0]  ramRaddr,
    output logic [countWidth-1:0] ramRdata
);

    // one word per (pixel, bin)
    logic [countWidth-1:0] mem [depth];

    // write port
    always_ff @(posedge clk) begin
        if (ramWrite) begin
            mem[ramWaddr] <= ramWdata;
        end
    end

    // registered read port
    // same-address read and write returns the old word
    // and the controller forwards around this
    always_ff @(posedge clk) begin
        ramRdata <= mem[ramRaddr];
    end

    // a write to an X address would corrupt an unknown word
    writeAddrKnown: assert property (
        @(posedge clk) ramWrite |-> !$isunknown(ramWaddr)
    ) else $error("histRam: write with unknown address");

endmodule

//--- logic/histFsm.sv
`timescale 1ns/1ps

module histFsm #(
    parameter int stampWidth = sifhPkg::defStampWidth,
    parameter int binBits = sifhPkg::defBinBits,
    parameter int countWidth = sifhPkg::defCountWidth,
    parameter int pixelNum = sifhPkg::defPixelNum,
    parameter int acqNum = sifhPkg::defAcqNum,
    parameter int dataNum = sifhPkg::defDataNum,
    localparam int pixWidth = (pixelNum > 1) ? $clog2(pixelNum) : 1,
    localparam int addrWidth = pixWidth + binBits,
    localparam int depth = pixelNum * (2 ** binBits),
    localparam int samplesPerPixel = acqNum * dataNum,
    localparam int cntWidth = (samplesPerPixel > 1) ? $clog2(samplesPerPixel) : 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dataStrobe,
    input  logic [stampWidth-1:0] data,
    input  logic [countWidth-1:0] ramRdata,
    output logic                  wrEn,
    output logic                  ramWrite,
    output logic [addrWidth-1:0]  ramWaddr,
    output logic [countWidth-1:0] ramWdata,
    output logic [addrWidth-1:0]  ramRaddr,
    output logic                  binValid,
    output logic                  binFirst,
    output logic                  binLast,
    output logic [pixWidth-1:0]   scanPixel
);

    sifhPkg::fsmState_t state, stateNext;

    logic [addrWidth-1:0]  clearAddr;
    logic [pixWidth-1:0]   pixel;
    logic [cntWidth-1:0]   sampleCnt;
    logic [binBits-1:0]    binCnt;
    logic                  scanDone;
    logic                  accept;
    logic                  lastSample;
    logic                  scanRead;
    logic [addrWidth-1:0]  sampleAddr;
    logic [addrWidth-1:0]  scanAddr;
    // stage 1 of the read-modify-write
    logic                  s1Valid;
    logic [addrWidth-1:0]  s1Addr;
    logic                  fwdHit;
    logic [countWidth-1:0] fwdData;
    logic [countWidth-1:0] baseCount;
    logic [countWidth-1:0] incCount;

    assign accept = dataStrobe && wrEn;
    assign lastSample = (sampleCnt == cntWidth'(samplesPerPixel - 1));
    // bin comes from the top timestamp bits
    assign sampleAddr = {pixel, data[stampWidth-1 -: binBits]};
    assign scanRead = (state == sifhPkg::stScan) && !scanDone;
    assign scanPixel = pixel;

    // stage 1 base: forwarded value if the previous write hit this word
    assign baseCount = fwdHit ? fwdData : ramRdata;
    // saturating increment
    assign incCount = (baseCount == '1) ? baseCount : baseCount + 1'b1;

    // scan reads take priority on the read port
    assign ramRaddr = scanRead ? {pixel, binCnt} : sampleAddr;

    always_comb begin
        stateNext = state;
        case (state)
            sifhPkg::stClear:
                if (clearAddr == addrWidth'(depth - 1)) stateNext = sifhPkg::stAccumulate;
            sifhPkg::stAccumulate:
                if (accept && lastSample) stateNext = sifhPkg::stDrain;
            // one cycle for the last increment to land
            sifhPkg::stDrain:
                stateNext = sifhPkg::stScan;
            // leave on the final zero write
            sifhPkg::stScan:
                if (binLast) stateNext = sifhPkg::stAccumulate;
            default:
                stateNext = sifhPkg::stClear;
        endcase
    end

    // write port mux: clear, increment, scan zeroing
    always_comb begin
        ramWrite = 1'b0;
        ramWaddr = s1Addr;
        ramWdata = '0;
        if (state == sifhPkg::stClear) begin
            ramWrite = 1'b1;
            ramWaddr = clearAddr;
        end else if (s1Valid) begin
            ramWrite = 1'b1;
            ramWdata = incCount;
        end else if (binValid) begin
            ramWrite = 1'b1;
            ramWaddr = scanAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= sifhPkg::stClear;
            wrEn <= 1'b0;
            clearAddr <= '0;
            pixel <= '0;
            sampleCnt <= '0;
            binCnt <= '0;
            scanDone <= 1'b0;
            s1Valid <= 1'b0;
            fwdHit <= 1'b0;
            binValid <= 1'b0;
            binFirst <= 1'b0;
            binLast <= 1'b0;
        end else begin
            state <= stateNext;
            // high exactly while accumulating
            wrEn <= (stateNext == sifhPkg::stAccumulate);
            if (state == sifhPkg::stClear) begin
                clearAddr <= clearAddr + 1'b1;
            end
            if (accept) begin
                sampleCnt <= lastSample ? '0 : sampleCnt + 1'b1;
            end
            s1Valid <= accept;
            // stage-1 write to the word just read, RAM returns stale data
            fwdHit <= accept && s1Valid && (s1Addr == sampleAddr);
            if (scanRead) begin
                binCnt <= binCnt + 1'b1;
                if (binCnt == '1) scanDone <= 1'b1;
            end
            // tags line up with the RAM read data
            binValid <= scanRead;
            binFirst <= scanRead && (binCnt == '0);
            binLast <= scanRead && (binCnt == '1);
            if (state == sifhPkg::stScan && binLast) begin
                scanDone <= 1'b0;
                pixel <= (pixel == pixWidth'(pixelNum - 1)) ? '0 : pixel + 1'b1;
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        s1Addr <= sampleAddr;
        fwdData <= incCount;
        scanAddr <= {pixel, binCnt};
    end

    // wrEn is registered from the next state, must agree with state
    wrEnOnlyAccumulate: assert property (
        @(posedge clk) disable iff (reset) wrEn |-> (state == sifhPkg::stAccumulate)
    ) else $error("histFsm: wrEn high outside accumulate");

    // scan pass leaves the histogram zeroed
    scanWritesZero: assert property (
        @(posedge clk) disable iff (reset)
        (ramWrite && state == sifhPkg::stScan) |-> (ramWdata == '0)
    ) else $error("histFsm: nonzero write during scan");

endmodule

//--- logic/peakFinder.sv
`timescale 1ns/1ps

module peakFinder #(
    parameter int binBits = sifhPkg::defBinBits,
    parameter int countWidth = sifhPkg::defCountWidth,
    parameter int pixelNum = sifhPkg::defPixelNum,
    localparam int pixWidth = (pixelNum > 1) ? $clog2(pixelNum) : 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  binValid,
    input  logic                  binFirst,
    input  logic                  binLast,
    input  logic [pixWidth-1:0]   scanPixel,
    input  logic [countWidth-1:0] ramRdata,
    output logic                  peakValid,
    output logic [pixWidth-1:0]   peakPixel,
    output logic [binBits-1:0]    peakBin,
    output logic [countWidth-1:0] peakCount
);

    sifhPkg::scanPhase_t phase;

    logic [pixWidth-1:0]   curPixel;
    logic [binBits-1:0]    binIdx;
    logic [binBits-1:0]    maxBin;
    logic [countWidth-1:0] maxCount;

    // control
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= sifhPkg::phIdle;
            peakValid <= 1'b0;
        end else begin
            peakValid <= 1'b0;
            case (phase)
                sifhPkg::phIdle, sifhPkg::phTrack: begin
                    if (binValid && binLast) phase <= sifhPkg::phEmit;
                    else if (binValid && binFirst) phase <= sifhPkg::phTrack;
                end
                // one pulse per pixel
                sifhPkg::phEmit: begin
                    peakValid <= 1'b1;
                    phase <= sifhPkg::phIdle;
                end
                default:
                    phase <= sifhPkg::phIdle;
            endcase
        end
    end

    // running max, strictly greater so ties keep the lower bin
    always_ff @(posedge clk) begin
        if (binValid) begin
            if (binFirst) begin
                curPixel <= scanPixel;
                maxCount <= ramRdata;
                maxBin <= '0;
                binIdx <= binBits'(1);
            end else begin
                binIdx <= binIdx + 1'b1;
                if (ramRdata > maxCount) begin
                    maxCount <= ramRdata;
                    maxBin <= binIdx;
                end
            end
        end
    end

    // result registers, loaded once the last bin is in
    always_ff @(posedge clk) begin
        if (phase == sifhPkg::phEmit) begin
            peakPixel <= curPixel;
            peakBin <= maxBin;
            peakCount <= maxCount;
        end
    end

    // back-to-back scans are at least a bin sweep apart
    singlePulse: assert property (
        @(posedge clk) disable iff (reset) peakValid |=> !peakValid
    ) else $error("peakFinder: peakValid held two cycles");

endmodule

//--- logic/sifhTop.sv
`timescale 1ns/1ps

module sifhTop #(
    parameter int stampWidth = sifhPkg::defStampWidth,
    parameter int binBits = sifhPkg::defBinBits,
    parameter int countWidth = sifhPkg::defCountWidth,
    parameter int pixelNum = sifhPkg::defPixelNum,
    parameter int acqNum = sifhPkg::defAcqNum,
    parameter int dataNum = sifhPkg::defDataNum,
    localparam int pixWidth = (pixelNum > 1) ? $clog2(pixelNum) : 1,
    localparam int addrWidth = pixWidth + binBits
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dataStrobe,
    input  logic [stampWidth-1:0] data,
    output logic                  wrEn,
    output logic                  peakValid,
    output logic [pixWidth-1:0]   peakPixel,
    output logic [binBits-1:0]    peakBin,
    output logic [countWidth-1:0] peakCount
);

    // RAM ports
    logic                  ramWrite;
    logic [addrWidth-1:0]  ramWaddr;
    logic [countWidth-1:0] ramWdata;
    logic [addrWidth-1:0]  ramRaddr;
    logic [countWidth-1:0] ramRdata;
    // scan tags toward the peak finder
    logic                  binValid;
    logic                  binFirst;
    logic                  binLast;
    logic [pixWidth-1:0]   scanPixel;

    histFsm #(
        .stampWidth(stampWidth),
        .binBits(binBits),
        .countWidth(countWidth),
        .pixelNum(pixelNum),
        .acqNum(acqNum),
        .dataNum(dataNum)
    ) histFsm_i (
        .clk(clk),
        .reset(reset),
        .dataStrobe(dataStrobe),
        .data(data),
        .ramRdata(ramRdata),
        .wrEn(wrEn),
        .ramWrite(ramWrite),
        .ramWaddr(ramWaddr),
        .ramWdata(ramWdata),
        .ramRaddr(ramRaddr),
        .binValid(binValid),
        .binFirst(binFirst),
        .binLast(binLast),
        .scanPixel(scanPixel)
    );

    histRam #(
        .binBits(binBits),
        .countWidth(countWidth),
        .pixelNum(pixelNum)
    ) histRam_i (
        .clk(clk),
        .ramWrite(ramWrite),
        .ramWaddr(ramWaddr),
        .ramWdata(ramWdata),
        .ramRaddr(ramRaddr),
        .ramRdata(ramRdata)
    );

    // samples RAM read data directly, tags come from the controller
    peakFinder #(
        .binBits(binBits),
        .countWidth(countWidth),
        .pixelNum(pixelNum)
    ) peakFinder_i (
        .clk(clk),
        .reset(reset),
        .binValid(binValid),
        .binFirst(binFirst),
        .binLast(binLast),
        .scanPixel(scanPixel),
        .ramRdata(ramRdata),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakBin(peakBin),
        .peakCount(peakCount)
    );

endmodule

//--- bench/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int periodNs = 4,
    parameter int resetCycles = 2
) (
    output logic clk,
    output logic reset
);

    // free-running clock
    initial begin
        clk = 1'b0;
        forever begin
            #(periodNs / 2.0) clk = ~clk;
        end
    end

    // held high for resetCycles rising edges, then released on an edge
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- bench/sifhChecker.sv
`timescale 1ns/1ps

module sifhChecker #(
    parameter int stampWidth = sifhPkg::defStampWidth,
    parameter int binBits = sifhPkg::defBinBits,
    parameter int countWidth = sifhPkg::defCountWidth,
    parameter int pixelNum = sifhPkg::defPixelNum,
    parameter int acqNum = sifhPkg::defAcqNum,
    parameter int dataNum = sifhPkg::defDataNum,
    localparam int pixWidth = (pixelNum > 1) ? $clog2(pixelNum) : 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dataStrobe,
    input  logic [stampWidth-1:0] data,
    input  logic [1:0]            patternId,
    input  logic                  wrEn,
    input  logic                  peakValid,
    input  logic [pixWidth-1:0]   peakPixel,
    input  logic [binBits-1:0]    peakBin,
    input  logic [countWidth-1:0] peakCount,
    output int                    passCount,
    output int                    failCount,
    output int                    skipCount,
    output int                    doneCount
);

    localparam int nBins = 2 ** binBits;
    localparam int maxCount = (2 ** countWidth) - 1;
    localparam int samplesPerPixel = acqNum * dataNum;
    localparam int clearCycles = pixelNum * nBins;
    localparam int lowBits = stampWidth - binBits;

    sifhPkg::fsmState_t clearState = sifhPkg::stClear;

    int nPass = 0;
    int nFail = 0;
    int nSkip = 0;
    int nDone = 0;
    logic skipShown = 1'b0;
    // model histogram of the pixel being filled
    int hist [nBins];
    int sampleCnt;
    int sampleBin;
    int expPixel;
    int testIdx;
    int lastPattern;
    int clearCnt;
    logic clearDone;
    // expected results of finished pixels, oldest first
    int qPixel [$];
    int qBin [$];
    int qCount [$];
    int qName [$];

    assign passCount = nPass;
    assign failCount = nFail;
    assign skipCount = nSkip;
    assign doneCount = nDone;

    function automatic string patternName(input int id);
        case (id)
            0: return "singleBin";
            1: return "backToBack";
            2: return "tieLow";
            default: return "randomBins";
        endcase
    endfunction

    // strictly greater wins, so a tie keeps the lowest bin
    task automatic pushExpected();
        int b;
        int bestBin;
        int bestCount;
        bestBin = 0;
        bestCount = hist[0];
        for (b = 1; b < nBins; b++) begin
            if (hist[b] > bestCount) begin
                bestBin = b;
                bestCount = hist[b];
            end
        end
        qPixel.push_back(expPixel);
        qBin.push_back(bestBin);
        qCount.push_back(bestCount);
        qName.push_back(testIdx * 4 + lastPattern);
    endtask

    task automatic comparePeak();
        int ePixel;
        int eBin;
        int eCount;
        int tag;
        string name;
        if (qPixel.size() == 0) begin
            $display("peakValid pulsed with no finished pixel waiting for a result");
            nFail++;
            return;
        end
        ePixel = qPixel.pop_front();
        eBin = qBin.pop_front();
        eCount = qCount.pop_front();
        tag = qName.pop_front();
        name = $sformatf("test%0d %s", tag / 4, patternName(tag % 4));
        if (int'(peakPixel) == ePixel && int'(peakBin) == eBin && int'(peakCount) == eCount) begin
            $display("PASS %s: pixel %0d bin %0d count %0d", name, ePixel, eBin, eCount);
            nPass++;
        end else begin
            $display("ERROR %s: expected pixel %0d bin %0d count %0d, actual pixel %0d bin %0d count %0d",
                name, ePixel, eBin, eCount, peakPixel, peakBin, peakCount);
            nFail++;
        end
        nDone++;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            sampleCnt = 0;
            expPixel = 0;
            testIdx = 0;
            clearCnt = 0;
            clearDone = 1'b0;
            foreach (hist[i]) hist[i] = 0;
            // default sizes never reach the count limit
            if (!skipShown && samplesPerPixel <= maxCount) begin
                $display("SKIP saturation: %0d samples per pixel cannot pass count %0d",
                    samplesPerPixel, maxCount);
                nSkip = 1;
            end
            skipShown = 1'b1;
        end else begin
            // clear after reset: wrEn low for one write per RAM word
            if (!clearDone) begin
                if (peakValid) begin
                    $display("peakValid pulsed during the clear after reset");
                    nFail++;
                end
                if (wrEn) begin
                    clearDone = 1'b1;
                    if (clearCnt == clearCycles) begin
                        $display("PASS clearAfterReset: %s lasted %0d cycles",
                            clearState.name(), clearCnt);
                        nPass++;
                    end else begin
                        $display("ERROR clearAfterReset: expected %0d cycles, actual %0d",
                            clearCycles, clearCnt);
                        nFail++;
                    end
                end else begin
                    clearCnt++;
                end
            end
            // accepted sample, same rule as the DUT port
            if (dataStrobe && wrEn) begin
                sampleBin = int'(data >> lowBits);
                if (hist[sampleBin] < maxCount) hist[sampleBin]++;
                lastPattern = int'(patternId);
                sampleCnt++;
                if (sampleCnt == samplesPerPixel) begin
                    pushExpected();
                    foreach (hist[i]) hist[i] = 0;
                    sampleCnt = 0;
                    testIdx++;
                    expPixel = (expPixel + 1) % pixelNum;
                end
            end
            if (peakValid) comparePeak();
        end
    end

endmodule

//--- bench/sifhTb.sv
`timescale 1ns/1ps

module sifhTb;

    localparam int stampWidth = sifhPkg::defStampWidth;
    localparam int binBits = sifhPkg::defBinBits;
    localparam int countWidth = sifhPkg::defCountWidth;
    localparam int pixelNum = sifhPkg::defPixelNum;
    localparam int acqNum = sifhPkg::defAcqNum;
    localparam int dataNum = sifhPkg::defDataNum;
    localparam int pixWidth = (pixelNum > 1) ? $clog2(pixelNum) : 1;
    localparam int nBins = 2 ** binBits;
    localparam int lowBits = stampWidth - binBits;
    localparam int samplesPerPixel = acqNum * dataNum;
    // one directed frame, then three random frames
    localparam int numTests = 4 * pixelNum;
    localparam int maxGap = 3;
    localparam int resetCycles = 2;
    localparam int timeoutCycles = resetCycles + pixelNum * nBins
        + numTests * (samplesPerPixel * (maxGap + 1) + nBins + 10);

    localparam logic [1:0] patSingle = 2'd0;
    localparam logic [1:0] patBackToBack = 2'd1;
    localparam logic [1:0] patTie = 2'd2;
    localparam logic [1:0] patRandom = 2'd3;

    logic                  clk;
    logic                  reset;
    logic                  dataStrobe;
    logic [stampWidth-1:0] data;
    logic [1:0]            patternId;
    logic                  wrEn;
    logic                  peakValid;
    logic [pixWidth-1:0]   peakPixel;
    logic [binBits-1:0]    peakBin;
    logic [countWidth-1:0] peakCount;
    int                    passCount;
    int                    failCount;
    int                    skipCount;
    int                    doneCount;
    int                    cycles = 0;
    // wrEn at mid cycle, settled before the next rising edge
    logic                  wrEnSeen = 1'b0;

    clockGen #(.periodNs(4), .resetCycles(resetCycles)) clockGen_i (
        .clk(clk),
        .reset(reset)
    );

    sifhTop #(
        .stampWidth(stampWidth), .binBits(binBits), .countWidth(countWidth),
        .pixelNum(pixelNum), .acqNum(acqNum), .dataNum(dataNum)
    ) sifhTop_i (
        .clk(clk), .reset(reset), .dataStrobe(dataStrobe), .data(data),
        .wrEn(wrEn), .peakValid(peakValid), .peakPixel(peakPixel),
        .peakBin(peakBin), .peakCount(peakCount)
    );

    sifhChecker #(
        .stampWidth(stampWidth), .binBits(binBits), .countWidth(countWidth),
        .pixelNum(pixelNum), .acqNum(acqNum), .dataNum(dataNum)
    ) sifhChecker_i (
        .clk(clk), .reset(reset), .dataStrobe(dataStrobe), .data(data),
        .patternId(patternId), .wrEn(wrEn), .peakValid(peakValid),
        .peakPixel(peakPixel), .peakBin(peakBin), .peakCount(peakCount),
        .passCount(passCount), .failCount(failCount), .skipCount(skipCount),
        .doneCount(doneCount)
    );

    always @(negedge clk) begin
        wrEnSeen = wrEn;
    end

    // bin in the top bits, random fine time below
    function automatic logic [stampWidth-1:0] makeStamp(input int bin);
        logic [stampWidth-1:0] stamp;
        stamp = stampWidth'(bin) << lowBits;
        stamp = stamp | stampWidth'($urandom_range((2 ** lowBits) - 1, 0));
        return stamp;
    endfunction

    task automatic idleCycle();
        @(posedge clk);
        dataStrobe <= 1'b0;
    endtask

    task automatic sendSample(input int bin, input int gap);
        repeat (gap) idleCycle();
        while (!wrEnSeen) idleCycle();
        @(posedge clk);
        dataStrobe <= 1'b1;
        data <= makeStamp(bin);
    endtask

    // strobes during drain and scan, wrEn is low for the whole bin sweep
    task automatic sendIgnored();
        int n;
        n = $urandom_range(6, 1);
        repeat (n) begin
            @(posedge clk);
            dataStrobe <= 1'b1;
            data <= makeStamp($urandom_range(nBins - 1, 0));
        end
        idleCycle();
    endtask

    task automatic runPixel(input int t);
        logic [1:0] pat;
        int binA;
        int binB;
        int bin;
        int gap;
        int s;
        pat = (t < 4) ? t[1:0] : patRandom;
        binA = $urandom_range(nBins - 2, 0);
        binB = $urandom_range(nBins - 1, binA + 1);
        patternId <= pat;
        for (s = 0; s < samplesPerPixel; s++) begin
            gap = $urandom_range(maxGap, 0);
            case (pat)
                patSingle: bin = binA;
                // mostly one bin back to back, hits the forwarding path
                patBackToBack: begin
                    bin = ($urandom_range(3, 0) == 0) ? binB : binA;
                    gap = 0;
                end
                // upper bin first, equal counts
                patTie: bin = s[0] ? binA : binB;
                default: bin = $urandom_range(nBins - 1, 0);
            endcase
            sendSample(bin, gap);
        end
        sendIgnored();
    endtask

    initial begin
        int t;
        void'($urandom(62880));
        dataStrobe = 1'b0;
        data = '0;
        patternId = 2'd0;
        wait (reset === 1'b0);
        for (t = 0; t < numTests; t++) begin
            runPixel(t);
        end
        while (doneCount < numTests) begin
            @(negedge clk);
        end
        @(negedge clk);
        $display("tests: %0d passed, %0d failed, %0d skipped", passCount, failCount, skipCount);
        if (failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            $display("timeout: peakValid missing, %0d of %0d pixel results within %0d cycles",
                doneCount, numTests, timeoutCycles);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

//--- vlog.f
logic/sifhPkg.sv
logic/histRam.sv
logic/histFsm.sv
logic/peakFinder.sv
logic/sifhTop.sv
bench/clockGen.sv
bench/sifhChecker.sv
bench/sifhTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= sifhTb
FILELIST ?= vlog.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
FAIL_MSG ?= Simulation failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: build
	@./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)
